/* source/probe_pkg.sv */
`default_nettype none

package probe_pkg;

    // Bits 15:14 of an address pick the region and the rest is per-region detail
    typedef logic [15:0] io_addr_t;
    typedef logic [15:0] io_data_t;

    // Rising edges of the measured input seen in one gate window
    typedef logic [27:0] freq_code_t;

    typedef logic [7:0] lcd_data_t;

    typedef enum logic [1:0] {
        region_lcd  = 2'd0,
        region_freq = 2'd1,
        region_i2c  = 2'd2,
        region_irq  = 2'd3
    } io_region_t;

endpackage

`default_nettype wire

/* source/frequency_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module frequency_counter #(
    parameter int GATE_CYCLES = 1000
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  sig,
    input  wire logic                  freq_clear,
    output probe_pkg::freq_code_t      code,
    output logic                       ready
);

    localparam int GATE_W = $clog2(GATE_CYCLES);

    logic [2:0]            sig_sync;   // Two sync stages plus one for edge detect
    logic                  rise;
    logic                  gate_end;
    logic [GATE_W-1:0]     gate_cnt;
    probe_pkg::freq_code_t edge_cnt;

    assign rise     = sig_sync[1] & ~sig_sync[2];
    assign gate_end = (gate_cnt == GATE_W'(GATE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sig_sync <= '0;
            gate_cnt <= '0;
            edge_cnt <= '0;
            ready    <= 1'b0;
        end else begin
            sig_sync <= {sig_sync[1:0], sig};
            if (gate_end) begin
                gate_cnt <= '0;
                edge_cnt <= '0;         // Next window starts right away
                ready    <= 1'b1;
            end else begin
                gate_cnt <= gate_cnt + 1'b1;
                edge_cnt <= edge_cnt + probe_pkg::freq_code_t'(rise);
                if (freq_clear)
                    ready <= 1'b0;
            end
        end
    end

    // The edge on the last gate cycle still belongs to this window
    always_ff @(posedge clk) begin
        if (gate_end)
            code <= edge_cnt + probe_pkg::freq_code_t'(rise);
    end

endmodule

`default_nettype wire

/* source/logic_probe_led.sv */
`timescale 1ns/1ps
`default_nettype none

module logic_probe_led #(
    parameter int STRETCH_WIDTH = 16
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic comp_hi,
    input  wire logic comp_lo,
    output logic      led_one,
    output logic      led_zero,
    output logic      led_floating,
    output logic      led_pulse
);

    logic [1:0]               hi_sync;
    logic [1:0]               lo_sync;
    logic [2:0]               level;      // One-hot {one, zero, floating}
    logic                     changed;
    logic [STRETCH_WIDTH-1:0] stretch;

    always_comb begin
        if (hi_sync[1])
            level = 3'b100;
        else if (!lo_sync[1])
            level = 3'b010;
        else
            level = 3'b001;     // Between thresholds, nothing is driving the tip
    end

    // The LED registers hold the previous level, so compare against them
    assign changed = (level != {led_one, led_zero, led_floating});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_sync      <= '0;
            lo_sync      <= '0;
            led_one      <= 1'b0;
            led_zero     <= 1'b0;
            led_floating <= 1'b0;
            led_pulse    <= 1'b0;
            stretch      <= '0;
        end else begin
            hi_sync <= {hi_sync[0], comp_hi};
            lo_sync <= {lo_sync[0], comp_lo};
            {led_one, led_zero, led_floating} <= level;
            led_pulse <= changed || (stretch != '0);
            if (changed)
                stretch <= '1;
            else if (stretch != '0)
                stretch <= stretch - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/io_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module io_arbiter (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                host_req,
    input  wire logic                host_we,
    input  wire probe_pkg::io_addr_t host_addr,
    input  wire probe_pkg::io_data_t host_wdata,
    output logic                     host_gnt,
    output logic                     host_rvalid,
    output probe_pkg::io_data_t      host_rdata,
    input  wire logic                log_req,
    input  wire logic                log_we,
    input  wire probe_pkg::io_addr_t log_addr,
    input  wire probe_pkg::io_data_t log_wdata,
    output logic                     log_gnt,
    output logic                     log_rvalid,
    output probe_pkg::io_data_t      log_rdata,
    output logic                     bus_sel,
    output logic                     bus_we,
    output probe_pkg::io_addr_t      bus_addr,
    output probe_pkg::io_data_t      bus_wdata,
    input  wire probe_pkg::io_data_t bus_rdata
);

    assign host_gnt = host_req;                 // Host is never blocked
    assign log_gnt  = log_req & ~host_req;

    assign bus_sel   = host_req | log_req;
    assign bus_we    = host_req ? host_we    : log_we;
    assign bus_addr  = host_req ? host_addr  : log_addr;
    assign bus_wdata = host_req ? host_wdata : log_wdata;

    // Remember the winner so the registered read data goes back to it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_rvalid <= 1'b0;
            log_rvalid  <= 1'b0;
        end else begin
            host_rvalid <= host_gnt;
            log_rvalid  <= log_gnt;
        end
    end

    assign host_rdata = host_rvalid ? bus_rdata : '0;
    assign log_rdata  = log_rvalid  ? bus_rdata : '0;

endmodule

`default_nettype wire

/* source/io_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module io_registers #(
    parameter int TIMER_BITS = 20
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  bus_sel,
    input  wire logic                  bus_we,
    input  wire probe_pkg::io_addr_t   bus_addr,
    input  wire probe_pkg::io_data_t   bus_wdata,
    output probe_pkg::io_data_t        bus_rdata,
    input  wire probe_pkg::freq_code_t code,
    input  wire logic                  ready,
    output logic                       freq_clear,
    output probe_pkg::lcd_data_t       lcd_data,
    output logic                       lcd_dc,
    output logic                       lcd_e,
    output logic                       scl_low,
    output logic                       sda_low,
    input  wire logic                  scl_in,
    input  wire logic                  sda_in,
    input  wire logic                  button,
    output logic                       timer_irq
);

    probe_pkg::io_region_t region;
    logic                  wr;
    logic                  rd;
    logic [TIMER_BITS-1:0] timer;

    assign region = probe_pkg::io_region_t'(bus_addr[15:14]);
    assign wr     = bus_sel & bus_we;
    assign rd     = bus_sel & ~bus_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lcd_dc     <= 1'b0;
            lcd_e      <= 1'b0;
            scl_low    <= 1'b0;
            sda_low    <= 1'b0;
            freq_clear <= 1'b0;
        end else begin
            // Reading the low half consumes the result
            freq_clear <= rd && (region == probe_pkg::region_freq) && !bus_addr[0];
            if (wr && region == probe_pkg::region_lcd)
                {lcd_dc, lcd_e} <= bus_addr[1:0];
            if (wr && region == probe_pkg::region_i2c) begin
                scl_low <= ~bus_wdata[1];   // A one releases the line
                sda_low <= ~bus_wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && region == probe_pkg::region_lcd)
            lcd_data <= bus_wdata[7:0];
        if (rd) begin
            case (region)
                probe_pkg::region_freq:
                    bus_rdata <= bus_addr[0] ? {ready, 3'b000, code[27:16]} : code[15:0];
                probe_pkg::region_i2c:
                    bus_rdata <= {13'd0, button, scl_in, sda_in};
                default:
                    bus_rdata <= '0;
            endcase
        end
    end

    // The timer runs freely and a set wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer     <= '0;
            timer_irq <= 1'b0;
        end else begin
            timer <= timer + 1'b1;
            if (timer == '1)
                timer_irq <= 1'b1;
            else if (wr && region == probe_pkg::region_irq && bus_wdata[0])
                timer_irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/freq_logger.sv */
`timescale 1ns/1ps
`default_nettype none

module freq_logger (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                ready,
    output logic                     req,
    output logic                     we,
    output probe_pkg::io_addr_t      addr,
    output probe_pkg::io_data_t      wdata,
    input  wire logic                gnt,
    input  wire logic                rvalid,
    input  wire probe_pkg::io_data_t rdata,
    output probe_pkg::freq_code_t    log_code,
    output logic [7:0]               log_count
);

    typedef enum logic [2:0] {
        idle,
        read_hi,
        wait_hi,
        read_lo,
        wait_lo,
        settle
    } state_t;

    state_t      state;
    logic [11:0] code_hi;

    assign req   = (state == read_hi) || (state == read_lo);
    assign we    = 1'b0;      // The logger only ever reads
    assign wdata = '0;
    assign addr  = {probe_pkg::region_freq, 13'd0, state == read_hi};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            log_count <= '0;
        end else begin
            case (state)
                idle:    if (ready) state <= read_hi;
                read_hi: if (gnt) state <= wait_hi;
                wait_hi: if (rvalid) state <= read_lo;
                read_lo: if (gnt) state <= wait_lo;
                wait_lo: if (rvalid) begin
                    state     <= settle;
                    log_count <= log_count + 1'b1;
                end
                default: state <= idle;   // Lets the cleared ready flag settle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wait_hi && rvalid)
            code_hi <= rdata[11:0];
        if (state == wait_lo && rvalid)
            log_code <= {code_hi, rdata};
    end

endmodule

`default_nettype wire

/* source/probe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module probe_top #(
    parameter int GATE_CYCLES   = 1000,
    parameter int STRETCH_WIDTH = 16,
    parameter int TIMER_BITS    = 20
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                host_req,
    input  wire logic                host_we,
    input  wire probe_pkg::io_addr_t host_addr,
    input  wire probe_pkg::io_data_t host_wdata,
    output logic                     host_gnt,
    output logic                     host_rvalid,
    output probe_pkg::io_data_t      host_rdata,
    input  wire logic                sig_hi,
    input  wire logic                sig_lo,
    input  wire logic                button,
    input  wire logic                scl_in,
    input  wire logic                sda_in,
    output logic                     led_one,
    output logic                     led_zero,
    output logic                     led_floating,
    output logic                     led_pulse,
    output probe_pkg::lcd_data_t     lcd_data,
    output logic                     lcd_dc,
    output logic                     lcd_e,
    output logic                     scl_low,
    output logic                     sda_low,
    output logic                     timer_irq,
    output probe_pkg::freq_code_t    log_code,
    output logic [7:0]               log_count
);

    probe_pkg::freq_code_t code;
    logic                  ready;
    logic                  freq_clear;

    logic                  log_req, log_we, log_gnt, log_rvalid;
    probe_pkg::io_addr_t   log_addr;
    probe_pkg::io_data_t   log_wdata, log_rdata;

    logic                  bus_sel, bus_we;
    probe_pkg::io_addr_t   bus_addr;
    probe_pkg::io_data_t   bus_wdata, bus_rdata;

    frequency_counter #(.GATE_CYCLES(GATE_CYCLES)) u_freq (
        .clk(clk), .rst_n(rst_n), .sig(sig_hi), .freq_clear(freq_clear),
        .code(code), .ready(ready)
    );

    logic_probe_led #(.STRETCH_WIDTH(STRETCH_WIDTH)) u_probe (
        .clk(clk), .rst_n(rst_n), .comp_hi(sig_hi), .comp_lo(sig_lo),
        .led_one(led_one), .led_zero(led_zero), .led_floating(led_floating),
        .led_pulse(led_pulse)
    );

    // The counter's ready doubles as the logger's interrupt line
    freq_logger u_logger (
        .clk(clk), .rst_n(rst_n), .ready(ready),
        .req(log_req), .we(log_we), .addr(log_addr), .wdata(log_wdata),
        .gnt(log_gnt), .rvalid(log_rvalid), .rdata(log_rdata),
        .log_code(log_code), .log_count(log_count)
    );

    io_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_gnt(host_gnt), .host_rvalid(host_rvalid),
        .host_rdata(host_rdata),
        .log_req(log_req), .log_we(log_we), .log_addr(log_addr),
        .log_wdata(log_wdata), .log_gnt(log_gnt), .log_rvalid(log_rvalid),
        .log_rdata(log_rdata),
        .bus_sel(bus_sel), .bus_we(bus_we), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata)
    );

    io_registers #(.TIMER_BITS(TIMER_BITS)) u_regs (
        .clk(clk), .rst_n(rst_n),
        .bus_sel(bus_sel), .bus_we(bus_we), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
        .code(code), .ready(ready), .freq_clear(freq_clear),
        .lcd_data(lcd_data), .lcd_dc(lcd_dc), .lcd_e(lcd_e),
        .scl_low(scl_low), .sda_low(sda_low), .scl_in(scl_in), .sda_in(sda_in),
        .button(button), .timer_irq(timer_irq)
    );

endmodule

`default_nettype wire

/* tb/probe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module probe_tb;

    localparam int GATE = 200;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  host_req, host_we, host_gnt, host_rvalid;
    probe_pkg::io_addr_t   host_addr;
    probe_pkg::io_data_t   host_wdata, host_rdata;
    logic                  sig_hi = 1'b0;
    logic                  sig_lo, button, scl_in, sda_in;
    logic                  led_one, led_zero, led_floating, led_pulse;
    probe_pkg::lcd_data_t  lcd_data;
    logic                  lcd_dc, lcd_e, scl_low, sda_low, timer_irq;
    probe_pkg::freq_code_t log_code;
    logic [7:0]            log_count;

    logic [31:0]           lcg_state = 32'd96;
    int                    wave_period = 0;   // Zero lets probe_hi drive sig_hi
    int                    wave_phase = 0;
    logic                  probe_hi = 1'b0;

    probe_pkg::lcd_data_t  exp_lcd;
    logic                  exp_dc, exp_e, exp_scl_low, exp_sda_low, exp_irq;

    probe_top #(.GATE_CYCLES(GATE), .STRETCH_WIDTH(4), .TIMER_BITS(7)) u_dut (.*);

    always #5 clk = ~clk;

    // Square wave on sig_hi with the settings taken at the edge and applied 1 ns later
    always @(posedge clk) begin
        int   period;
        logic next_hi;
        period  = wave_period;
        next_hi = probe_hi;
        #1;
        if (period == 0) begin
            sig_hi     = next_hi;
            wave_phase = 0;
        end else begin
            sig_hi     = (wave_phase < period / 2);
            wave_phase = (wave_phase + 1 >= period) ? 0 : wave_phase + 1;
        end
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];        // Upper bits have the longer period
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand()) % n;
    endfunction

    // Expected LEDs as {one, zero, floating}
    function automatic logic [2:0] classify(input logic hi, input logic lo);
        if (hi)
            return 3'b100;
        if (!lo)
            return 3'b010;
        return 3'b001;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string what, input probe_pkg::io_data_t got,
                              input probe_pkg::io_data_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp));
    endtask

    task automatic check_lcd(input string what, input probe_pkg::lcd_data_t got,
                             input probe_pkg::lcd_data_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp));
    endtask

    task automatic check_code(input string what, input probe_pkg::freq_code_t got,
                              input probe_pkg::freq_code_t exp, input int tol);
        int diff;
        diff = int'(got) - int'(exp);
        if (diff > tol || diff < -tol)
            abort_run($sformatf("Fail %0t: %s got %0d expected %0d +/- %0d",
                                $time, what, got, exp, tol));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One host access that starts and ends 1 ns after a rising edge
    task automatic host_access(input logic we, input probe_pkg::io_addr_t addr,
                               input probe_pkg::io_data_t wdata,
                               output probe_pkg::io_data_t rdata);
        int waited;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        waited     = 0;
        #1;
        while (!host_gnt) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 20)
                abort_run("Timeout: host_gnt never came for a host request");
        end
        check_bit("host_gnt in the request cycle", waited == 0, 1'b1);
        @(posedge clk);
        #1;
        host_req = 1'b0;
        rdata    = '0;
        if (!we) begin
            waited = 0;
            while (!host_rvalid) begin
                step_cycles(1);
                waited++;
                if (waited > 20)
                    abort_run("Timeout: host_rvalid never came after a host read");
            end
            check_bit("host_rvalid one cycle after gnt", waited == 0, 1'b1);
            rdata = host_rdata;
        end
    endtask

    task automatic lcd_write_check();
        probe_pkg::io_addr_t addr;
        probe_pkg::io_data_t wdata, rd;
        addr  = {2'b00, 14'(next_rand())};
        wdata = next_rand();
        host_access(1'b1, addr, wdata, rd);
        exp_lcd = wdata[7:0];
        exp_dc  = addr[1];
        exp_e   = addr[0];
        check_lcd("lcd_data", lcd_data, exp_lcd);
        check_bit("lcd_dc", lcd_dc, exp_dc);
        check_bit("lcd_e", lcd_e, exp_e);
    endtask

    task automatic i2c_write_check();
        probe_pkg::io_data_t wdata, rd;
        wdata = next_rand();
        host_access(1'b1, {2'b10, 14'(next_rand())}, wdata, rd);
        exp_scl_low = ~wdata[1];
        exp_sda_low = ~wdata[0];
        check_bit("scl_low", scl_low, exp_scl_low);
        check_bit("sda_low", sda_low, exp_sda_low);
    endtask

    task automatic i2c_read_check();
        probe_pkg::io_data_t rd;
        scl_in = 1'(next_rand());
        sda_in = 1'(next_rand());
        button = 1'(next_rand());
        host_access(1'b0, {2'b10, 14'(next_rand())}, '0, rd);
        check_data("I2C and button read", rd, {13'd0, button, scl_in, sda_in});
    endtask

    task automatic random_host_op();
        probe_pkg::io_data_t rd;
        case (rand_below(4))
            0: lcd_write_check();
            1: i2c_write_check();
            2: i2c_read_check();
            default: begin
                host_access(1'b0, 16'h4001, '0, rd);  // High half leaves ready set
                // A count of at most GATE edges leaves code bits 27:16 at zero
                check_data("frequency high half below bit 15", rd & 16'h7FFF, '0);
            end
        endcase
    endtask

    task automatic wait_irq_rise();
        int waited;
        waited = 0;
        while (!timer_irq) begin
            step_cycles(1);
            waited++;
            if (waited > 130)
                abort_run("Timeout: timer_irq did not rise within 130 cycles");
        end
        exp_irq = 1'b1;
    endtask

    task automatic wait_log_step();
        logic [7:0] start;
        int         waited;
        start  = log_count;
        waited = 0;
        while (log_count == start) begin
            step_cycles(1);
            waited++;
            if (waited > 3 * GATE)
                abort_run("Timeout: the logger produced no new frequency result");
        end
    endtask

    task automatic timer_test();
        probe_pkg::io_data_t rd;
        repeat (3) begin
            wait_irq_rise();
            host_access(1'b1, 16'hC000, next_rand() & 16'hFFFE, rd);
            check_bit("timer_irq after write without bit 0", timer_irq, exp_irq);
            host_access(1'b0, {2'b11, 14'(next_rand())}, '0, rd);
            check_data("region 3 read", rd, '0);
            host_access(1'b1, {2'b11, 14'(next_rand())}, next_rand() | 16'h0001, rd);
            exp_irq = 1'b0;
            check_bit("timer_irq after clear", timer_irq, exp_irq);
        end
    endtask

    task automatic probe_test();
        logic       hi, lo, new_hi, new_lo;
        logic [2:0] leds;
        int         waited;
        repeat (8) begin
            hi       = 1'(next_rand());
            lo       = 1'(next_rand());
            probe_hi = hi;
            sig_lo   = lo;
            step_cycles(40);
            leds = classify(hi, lo);
            check_bit("led_one", led_one, leds[2]);
            check_bit("led_zero", led_zero, leds[1]);
            check_bit("led_floating", led_floating, leds[0]);
            check_bit("led_pulse on a steady level", led_pulse, 1'b0);
            new_hi = 1'(next_rand());
            new_lo = 1'(next_rand());
            if (classify(new_hi, new_lo) == leds)
                new_hi = ~new_hi;     // Flipping hi always moves the class
            probe_hi = new_hi;
            sig_lo   = new_lo;
            waited   = 0;
            while (!led_pulse) begin
                step_cycles(1);
                waited++;
                if (waited > 5)
                    abort_run("Timeout: led_pulse did not rise within 5 cycles");
            end
        end
    endtask

    task automatic frequency_test();
        repeat (3) begin
            wait_log_step();
            wave_period = 4 + rand_below(17);
            wait_log_step();      // This window saw the period change
            repeat (2) begin
                wait_log_step();
                check_code("log_code", log_code,
                           probe_pkg::freq_code_t'(GATE / wave_period), 1);
            end
        end
    endtask

    task automatic arbitration_test();
        logic [7:0] last;
        int         steps;
        int         ops;
        wait_log_step();
        wave_period = 4 + rand_below(17);
        last  = log_count;
        steps = 0;
        ops   = 0;
        while (steps < 4) begin
            random_host_op();
            step_cycles(rand_below(4));
            if (log_count != last) begin
                last = log_count;
                steps++;
                if (steps > 1)
                    check_code("log_code under host traffic", log_code,
                               probe_pkg::freq_code_t'(GATE / wave_period), 1);
            end
            ops++;
            if (ops > 600)
                abort_run("Timeout: the logger stalled during host traffic");
        end
    endtask

    initial begin
        probe_pkg::io_data_t rd;
        rst_n      = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        sig_lo     = 1'b0;
        button     = 1'b0;
        scl_in     = 1'b1;
        sda_in     = 1'b1;
        exp_irq    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        timer_test();
        repeat (20) lcd_write_check();
        host_access(1'b0, {2'b00, 14'(next_rand())}, '0, rd);
        check_data("region 0 read", rd, '0);
        check_lcd("lcd_data after read", lcd_data, exp_lcd);
        repeat (20) begin
            i2c_write_check();
            i2c_read_check();
        end
        probe_test();
        frequency_test();
        arbitration_test();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/probe_pkg.sv
source/frequency_counter.sv
source/logic_probe_led.sv
source/io_arbiter.sv
source/io_registers.sv
source/freq_logger.sv
source/probe_top.sv
tb/probe_tb.sv

/* Makefile */
TOP := probe_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o probe_sim
	./obj_dir/probe_sim

clean:
	rm -rf obj_dir
